// File: flist.f
hw/lsu_pkg.sv
hw/axi_pkg.sv
hw/load_format.sv
hw/resp_slot.sv
hw/lsu.sv
hw/axi_sram.sv
hw/lsu_top.sv
sim/clk_gen.sv
sim/lsu_assertions.sv
sim/tb_lsu_top.sv

// File: Bender.yml
package:
  name: lsu_axi

sources:
  - hw/lsu_pkg.sv
  - hw/axi_pkg.sv
  - hw/load_format.sv
  - hw/resp_slot.sv
  - hw/lsu.sv
  - hw/axi_sram.sv
  - hw/lsu_top.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/lsu_assertions.sv
      - sim/tb_lsu_top.sv

// File: sim/tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top;

	import lsu_pkg::*;
	import axi_pkg::*;

	localparam int timeout_cycles = 40;
	localparam int region_bytes = mem_words * 4;

	logic        clk;
	logic        rst_n;
	logic [2:0]  funct3;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] imm;
	logic        lsu_ren;
	logic        lsu_wen;
	logic        wb_valid;
	logic [31:0] lsu_val;
	logic        lsu_done;
	logic        lsu_err;

	logic [31:0] lfsr;
	// byte image of the sram region, index is the offset from mem_base
	logic [7:0]  model [region_bytes];

	clk_gen clk_u (.clk(clk), .rst_n(rst_n));

	lsu_top lsu_top_inst (
		.clk, .rst_n, .funct3, .src1, .src2, .imm,
		.lsu_ren, .lsu_wen, .wb_valid,
		.lsu_val, .lsu_done, .lsu_err
	);

	bind lsu lsu_assertions lsu_checks_u (
		.clk, .rst_n, .araddr, .arvalid, .arready, .rvalid, .rready,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bvalid, .bready
	);

	// galois lfsr, one step per bit
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic in_region(input logic [31:0] a);
		return (a >= mem_base) && (a < mem_base + region_bytes);
	endfunction

	// naturally aligned address within the first 2**bits words
	function automatic logic [31:0] pick_addr(input logic [2:0] f, input int bits);
		logic [31:0] idx;
		logic [1:0]  off;
		idx = next_bits(bits);
		case (f[1:0])
			2'b00:   off = 2'(next_bits(2));
			2'b01:   off = 2'(next_bits(1) << 1);
			default: off = 2'b00;
		endcase
		return mem_base + (idx << 2) + off;
	endfunction

	function automatic logic [31:0] expected_load(input logic [2:0] f, input logic [31:0] a);
		int b;
		b = a - mem_base;
		case (f)
			funct3_lb:  return {{24{model[b][7]}}, model[b]};
			funct3_lh:  return {{16{model[b+1][7]}}, model[b+1], model[b]};
			funct3_lw:  return {model[b+3], model[b+2], model[b+1], model[b]};
			funct3_lbu: return {24'h0, model[b]};
			funct3_lhu: return {16'h0, model[b+1], model[b]};
			default:    return '0;
		endcase
	endfunction

	function automatic void update_model(input logic [2:0] f, input logic [31:0] a,
			input logic [31:0] d);
		int b;
		b = a - mem_base;
		model[b] = d[7:0];
		if (f != funct3_sb) begin
			model[b+1] = d[15:8];
		end
		if (f == funct3_sw) begin
			model[b+2] = d[23:16];
			model[b+3] = d[31:24];
		end
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// called on a falling edge, returns on the falling edge that sees lsu_done
	task automatic issue_access(input logic is_load, input logic [2:0] f,
			input logic [31:0] a, input logic [31:0] d,
			output logic [31:0] val, output logic err);
		logic [11:0] i12;
		int          cycles;
		i12 = 12'(next_bits(12));
		funct3 = f;
		imm = {{20{i12[11]}}, i12};
		src1 = a - {{20{i12[11]}}, i12};
		src2 = d;
		lsu_ren = is_load;
		lsu_wen = !is_load;
		@(negedge clk);
		lsu_ren = 1'b0;
		lsu_wen = 1'b0;
		cycles = 0;
		while (lsu_done !== 1'b1) begin
			if (cycles == timeout_cycles) begin
				$display("access to %h got no lsu_done within %0d cycles", a, cycles);
				$display("sim failed");
				$fatal(1);
			end
			@(negedge clk);
			cycles++;
		end
		val = lsu_val;
		err = lsu_err;
	endtask

	task automatic verify_load(input logic [2:0] f, input logic [31:0] a, input string name);
		logic [31:0] val;
		logic        err;
		logic        hit;
		issue_access(1'b1, f, a, next_bits(32), val, err);
		hit = in_region(a);
		compare({name, " err"}, 32'(!hit), 32'(err));
		compare(name, hit ? expected_load(f, a) : 32'h0, val);
	endtask

	task automatic apply_store(input logic [2:0] f, input logic [31:0] a,
			input logic [31:0] d, input string name);
		logic [31:0] val;
		logic        err;
		issue_access(1'b0, f, a, d, val, err);
		compare({name, " err"}, 32'(!in_region(a)), 32'(err));
		if (in_region(a)) begin
			update_model(f, a, d);
		end
	endtask

	task automatic wait_reset();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1) begin
			if (cycles == 20) begin
				$display("reset was never released");
				$display("sim failed");
				$fatal(1);
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	initial begin
		logic [2:0]  f;
		logic [31:0] a;
		int          k;
		int          step;
		lfsr = 32'd91675;
		funct3 = '0;
		src1 = '0;
		src2 = '0;
		imm = '0;
		lsu_ren = 1'b0;
		lsu_wen = 1'b0;
		wb_valid = 1'b0;
		wait_reset();
		@(negedge clk);

		compare("reset lsu_val", 32'h0, lsu_val);
		compare("reset lsu_done", 32'h0, 32'(lsu_done));
		compare("reset lsu_err", 32'h0, 32'(lsu_err));

		// fill the whole region so every load has a known value
		for (int w = 0; w < mem_words; w++) begin
			apply_store(funct3_sw, mem_base + 4 * w, next_bits(32), "fill store");
		end

		// narrow and full stores merged into the word
		repeat (100) begin
			k = next_bits(2);
			f = (k == 0) ? funct3_sb : (k == 1) ? funct3_sh : funct3_sw;
			a = pick_addr(f, 10);
			apply_store(f, a, next_bits(32), "merge store");
			verify_load(funct3_lw, {a[31:2], 2'b00}, "merge readback");
		end

		// narrow loads at every legal offset
		for (int n = 0; n < 4; n++) begin
			case (n)
				0: f = funct3_lb;
				1: f = funct3_lh;
				2: f = funct3_lbu;
				default: f = funct3_lhu;
			endcase
			step = f[0] ? 2 : 1;
			for (int o = 0; o < 4; o += step) begin
				repeat (8) begin
					verify_load(f, mem_base + (next_bits(10) << 2) + o, "narrow load");
				end
			end
		end

		// outside the region, stores must not touch the aliased word
		verify_load(funct3_lw, mem_base + 32'h10, "before decerr");
		verify_load(funct3_lw, mem_base + 32'h1000, "decerr load high");
		verify_load(funct3_lb, 32'h7fff_ffff, "decerr load low");
		apply_store(funct3_sw, mem_base + 32'h1010, 32'h1234_5678, "decerr store high");
		verify_load(funct3_lw, mem_base + 32'h10, "alias high kept");
		apply_store(funct3_sh, 32'h7fff_fffe, 32'h0000_abcd, "decerr store low");
		verify_load(funct3_lw, mem_base + 32'hffc, "alias low kept");

		// writeback clears the load result
		apply_store(funct3_sw, mem_base + 32'h20, 32'hdead_beef, "wb store");
		verify_load(funct3_lw, mem_base + 32'h20, "wb load");
		wb_valid = 1'b1;
		@(negedge clk);
		wb_valid = 1'b0;
		compare("wb clear", 32'h0, lsu_val);

		// mixed traffic on a small window so accesses overlap
		repeat (400) begin
			k = next_bits(3);
			case (k)
				0: f = funct3_lb;
				1: f = funct3_lh;
				2: f = funct3_lw;
				3: f = funct3_lbu;
				4: f = funct3_lhu;
				5: f = funct3_sb;
				6: f = funct3_sh;
				default: f = funct3_sw;
			endcase
			a = pick_addr(f, 6);
			if (next_bits(4) == 0) begin
				a = a + 32'h1000;
			end
			if (k < 5) begin
				verify_load(f, a, "mixed load");
			end else begin
				apply_store(f, a, next_bits(32), "mixed store");
			end
		end

		$display("sim passed");
		$finish;
	end

endmodule

// File: sim/lsu_assertions.sv
`timescale 1ns/1ps

module lsu_assertions (
	input logic        clk,
	input logic        rst_n,
	input logic [31:0] araddr,
	input logic        arvalid,
	input logic        arready,
	input logic        rvalid,
	input logic        rready,
	input logic [31:0] awaddr,
	input logic        awvalid,
	input logic        awready,
	input logic [31:0] wdata,
	input logic [3:0]  wstrb,
	input logic        wvalid,
	input logic        wready,
	input logic        bvalid,
	input logic        bready
);

	logic r_owed;
	logic b_owed;

	// a response is owed from the address transfer until its own transfer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			r_owed <= 1'b0;
			b_owed <= 1'b0;
		end else begin
			if (arvalid && arready) begin
				r_owed <= 1'b1;
			end else if (rvalid && rready) begin
				r_owed <= 1'b0;
			end
			if (awvalid && awready) begin
				b_owed <= 1'b1;
			end else if (bvalid && bready) begin
				b_owed <= 1'b0;
			end
		end
	end

	ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid or araddr changed before the AR transfer");

	aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("awvalid or awaddr changed before the AW transfer");

	w_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else $error("wvalid or W payload changed before the W transfer");

	r_after_ar: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid |-> r_owed)
		else $error("rvalid without a prior AR transfer");

	b_after_aw: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid |-> b_owed)
		else $error("bvalid without a prior AW transfer");

	reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !arvalid && !awvalid && !wvalid && !rready && !bready)
		else $error("master valid or ready high after a reset edge");

endmodule

// File: sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset covers the first two rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [2:0]  funct3,
	input  logic [31:0] src1,
	input  logic [31:0] src2,
	input  logic [31:0] imm,
	input  logic        lsu_ren,
	input  logic        lsu_wen,
	input  logic        wb_valid,
	output logic [31:0] lsu_val,
	output logic        lsu_done,
	output logic        lsu_err
);

	logic [31:0] araddr;
	logic [2:0]  arsize;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic [31:0] awaddr;
	logic [2:0]  awsize;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;

	lsu lsu_u (
		.clk, .rst_n,
		.funct3, .src1, .src2, .imm,
		.lsu_ren, .lsu_wen, .wb_valid,
		.lsu_val, .lsu_done, .lsu_err,
		.araddr, .arsize, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.awaddr, .awsize, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready
	);

	axi_sram sram_u (
		.clk, .rst_n,
		.araddr, .arsize, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.awaddr, .awsize, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready
	);

endmodule

// File: hw/axi_sram.sv
`timescale 1ns/1ps

module axi_sram (
	input  logic        clk,
	input  logic        rst_n,

	input  logic [31:0] araddr,
	input  logic [2:0]  arsize,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,

	input  logic [31:0] awaddr,
	input  logic [2:0]  awsize,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready
);

	import lsu_pkg::*;
	import axi_pkg::*;

	logic [xlen-1:0] mem [mem_words];

	logic [31:0]                  ar_off;
	logic [31:0]                  aw_off;
	logic [$clog2(mem_words)-1:0] ar_idx;
	logic [$clog2(mem_words)-1:0] aw_idx;
	logic                         ar_hit;
	logic                         aw_hit;
	logic                         r_empty;
	logic                         b_empty;
	logic                         ar_fire;
	logic                         aw_fire;
	r_beat_t                      r_next;
	r_beat_t                      r_q;
	resp_t                        b_next;

	function automatic logic decode(input logic [31:0] a, input logic [2:0] s);
		return (a >= mem_base) && (a < mem_base + mem_words * 4) && (s <= size_w);
	endfunction

	assign ar_off = araddr - mem_base;
	assign aw_off = awaddr - mem_base;
	assign ar_idx = ar_off[$clog2(mem_words)+1:2];
	assign aw_idx = aw_off[$clog2(mem_words)+1:2];
	assign ar_hit = decode(araddr, arsize);
	assign aw_hit = decode(awaddr, awsize);

	// an address is taken only when its response has somewhere to go
	assign arready = arvalid & r_empty;
	assign ar_fire = arready;
	assign aw_fire = awvalid & wvalid & b_empty;
	assign awready = aw_fire;
	assign wready  = aw_fire;

	assign r_next.rdata = ar_hit ? mem[ar_idx] : '0;
	assign r_next.rresp = ar_hit ? resp_okay : resp_decerr;
	assign b_next       = aw_hit ? resp_okay : resp_decerr;

	always_ff @(posedge clk) begin
		if (aw_fire && aw_hit) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i]) begin
					mem[aw_idx][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	resp_slot #(.payload_t(r_beat_t)) r_slot_u (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (ar_fire),
		.payload_in (r_next),
		.ready      (rready),
		.valid      (rvalid),
		.payload    (r_q),
		.empty      (r_empty)
	);

	assign rdata = r_q.rdata;
	assign rresp = r_q.rresp;

	resp_slot #(.payload_t(resp_t)) b_slot_u (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (aw_fire),
		.payload_in (b_next),
		.ready      (bready),
		.valid      (bvalid),
		.payload    (bresp),
		.empty      (b_empty)
	);

endmodule

// File: hw/lsu.sv
`timescale 1ns/1ps

module lsu (
	input  logic        clk,
	input  logic        rst_n,

	input  logic [2:0]  funct3,
	input  logic [31:0] src1,
	input  logic [31:0] src2,
	input  logic [31:0] imm,
	input  logic        lsu_ren,
	input  logic        lsu_wen,
	input  logic        wb_valid,
	output logic [31:0] lsu_val,
	output logic        lsu_done,
	output logic        lsu_err,

	output logic [31:0] araddr,
	output logic [2:0]  arsize,
	output logic        arvalid,
	input  logic        arready,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp,
	input  logic        rvalid,
	output logic        rready,

	output logic [31:0] awaddr,
	output logic [2:0]  awsize,
	output logic        awvalid,
	input  logic        awready,
	output logic [31:0] wdata,
	output logic [3:0]  wstrb,
	output logic        wvalid,
	input  logic        wready,
	input  logic [1:0]  bresp,
	input  logic        bvalid,
	output logic        bready
);

	import lsu_pkg::*;
	import axi_pkg::*;

	logic [xlen-1:0] addr;
	logic [2:0]      size;
	logic [xlen-1:0] load_val;
	logic            ar_fire;
	logic            aw_fire;
	logic            r_fire;
	logic            b_fire;

	function automatic logic [3:0] byte_mask(input funct3_t f);
		case (f)
			funct3_sb: return 4'b0001;
			funct3_sh: return 4'b0011;
			funct3_sw: return 4'b1111;
			default:   return 4'b0000;
		endcase
	endfunction

	assign addr = src1 + imm;

	// code 3 is left as is so the slave rejects it
	always_comb begin
		case (funct3[1:0])
			2'b00:   size = size_b;
			2'b01:   size = size_h;
			2'b10:   size = size_w;
			default: size = 3'b011;
		endcase
	end

	assign araddr = addr;
	assign awaddr = addr;
	assign arsize = size;
	assign awsize = size;

	// store data and strobes move up to the byte lane
	assign wdata = src2 << {addr[1:0], 3'b000};
	assign wstrb = byte_mask(funct3) << addr[1:0];

	assign ar_fire = arvalid & arready;
	assign aw_fire = awvalid & awready;
	assign r_fire  = rvalid & rready;
	assign b_fire  = bvalid & bready;

	load_format fmt_u (
		.rword  (rdata),
		.offset (addr[1:0]),
		.funct3 (funct3),
		.value  (load_val)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			rready  <= 1'b0;
			bready  <= 1'b0;
		end else begin
			arvalid <= arvalid ? ~arready : lsu_ren;
			awvalid <= awvalid ? ~awready : lsu_wen;
			wvalid  <= wvalid ? ~wready : lsu_wen;
			// response readies only while something is outstanding
			rready  <= rready ? ~r_fire : ar_fire;
			bready  <= bready ? ~b_fire : aw_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lsu_done <= 1'b0;
			lsu_err  <= 1'b0;
		end else begin
			lsu_done <= r_fire | b_fire;
			lsu_err  <= (r_fire && rresp == resp_decerr) || (b_fire && bresp == resp_decerr);
		end
	end

	// writeback wins over a returning load
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lsu_val <= '0;
		end else if (wb_valid) begin
			lsu_val <= '0;
		end else if (r_fire) begin
			lsu_val <= load_val;
		end
	end

endmodule

// File: hw/resp_slot.sv
`timescale 1ns/1ps

module resp_slot #(
	parameter type payload_t = axi_pkg::resp_t
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     load,
	input  payload_t payload_in,
	input  logic     ready,
	output logic     valid,
	output payload_t payload,
	output logic     empty
);

	// load only arrives while empty, so it never meets a transfer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else if (load) begin
			valid <= 1'b1;
		end else if (valid && ready) begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			payload <= payload_in;
		end
	end

	assign empty = ~valid;

endmodule

// File: hw/load_format.sv
`timescale 1ns/1ps

module load_format (
	input  logic [31:0] rword,
	input  logic [1:0]  offset,
	input  logic [2:0]  funct3,
	output logic [31:0] value
);

	import lsu_pkg::*;

	logic [xlen-1:0] shifted;

	// bring the addressed byte lane down to bit 0
	assign shifted = rword >> {offset, 3'b000};

	always_comb begin
		case (funct3)
			funct3_lb: begin
				value = {{24{shifted[7]}}, shifted[7:0]};
			end
			funct3_lh: begin
				value = {{16{shifted[15]}}, shifted[15:0]};
			end
			funct3_lw: begin
				value = shifted;
			end
			funct3_lbu: begin
				value = {24'h0, shifted[7:0]};
			end
			funct3_lhu: begin
				value = {16'h0, shifted[15:0]};
			end
			default: begin
				value = '0;
			end
		endcase
	end

endmodule

// File: hw/axi_pkg.sv
package axi_pkg;

	typedef logic [1:0] resp_t;

	localparam resp_t resp_okay   = 2'b00;
	localparam resp_t resp_decerr = 2'b11;

	// bytes per beat as log2
	localparam logic [2:0] size_b = 3'b000;
	localparam logic [2:0] size_h = 3'b001;
	localparam logic [2:0] size_w = 3'b010;

	// single sram region, 4 KiB
	localparam logic [31:0] mem_base  = 32'h8000_0000;
	localparam int unsigned mem_words = 1024;

	typedef struct packed {
		logic [31:0] rdata;
		resp_t       rresp;
	} r_beat_t;

endpackage

// File: hw/lsu_pkg.sv
package lsu_pkg;

	// datapath width of the core
	localparam int xlen = 32;

	typedef logic [2:0] funct3_t;

	// load widths, bit 2 selects zero extension
	localparam funct3_t funct3_lb  = 3'b000;
	localparam funct3_t funct3_lh  = 3'b001;
	localparam funct3_t funct3_lw  = 3'b010;
	localparam funct3_t funct3_lbu = 3'b100;
	localparam funct3_t funct3_lhu = 3'b101;

	// store widths
	localparam funct3_t funct3_sb  = 3'b000;
	localparam funct3_t funct3_sh  = 3'b001;
	localparam funct3_t funct3_sw  = 3'b010;

endpackage
